//--- common/dtlb_cfg_pkg.sv
`default_nettype none

package dtlb_cfg_pkg;

    // Address geometry, 4 KiB pages
    parameter int VADDR_W    = 32;
    parameter int PADDR_W    = 32;
    parameter int PAGE_OFS_W = 12;
    parameter int VPN_W      = VADDR_W - PAGE_OFS_W;
    parameter int PPN_W      = PADDR_W - PAGE_OFS_W;

    // Pipeline ports into the DTLB
    parameter int LOAD_PORTS  = 2;
    parameter int STORE_PORTS = 1;

    // Queue index widths carried in the L2 tag
    parameter int LOAD_BANK_W  = 4;
    parameter int STORE_BANK_W = 3;

endpackage

`default_nettype wire

//--- common/dtlb_msg_pkg.sv
`default_nettype none

package dtlb_msg_pkg;

    parameter int SRC_W = 2;

    parameter logic [SRC_W-1:0] SRC_NONE  = 2'd0;
    parameter logic [SRC_W-1:0] SRC_LOAD  = 2'd1;
    parameter logic [SRC_W-1:0] SRC_STORE = 2'd2;

    parameter int TAG_W = 6;

    // Tag sent with an L2 request and echoed back, meaning depends on source
    typedef union packed {
        struct packed {
            logic                                  port;
            logic [dtlb_cfg_pkg::LOAD_BANK_W-1:0]  idx;
            logic [TAG_W-2-dtlb_cfg_pkg::LOAD_BANK_W:0] pad;
        } ld;
        struct packed {
            logic                                  port;  // Single store port, always 0
            logic [dtlb_cfg_pkg::STORE_BANK_W-1:0] idx;
            logic [TAG_W-2-dtlb_cfg_pkg::STORE_BANK_W:0] pad;
        } st;
    } l2_tag_u;

endpackage

`default_nettype wire

//--- dtlb/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_array
    import dtlb_cfg_pkg::*;
#(
    parameter int ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          req,
    input  logic [VADDR_W-1:0]            vaddr,
    input  logic                          fill_we,
    input  logic [$clog2(ENTRIES)-1:0]    fill_way,
    input  logic [VPN_W-1:0]              fill_vpn,
    input  logic [PPN_W-1:0]              fill_ppn,
    input  logic                          fill_uncache,
    output logic                          miss,
    output logic [PADDR_W-1:0]            paddr,
    output logic                          uncache
);

    logic [ENTRIES-1:0] valid;
    logic [VPN_W-1:0]   vpn_tab [ENTRIES];
    logic [PPN_W-1:0]   ppn_tab [ENTRIES];
    logic [ENTRIES-1:0] unc_tab;

    logic [VPN_W-1:0] lk_vpn;
    logic             hit;
    logic [PPN_W-1:0] hit_ppn;
    logic             hit_unc;

    assign lk_vpn = vaddr[VADDR_W-1:PAGE_OFS_W];

    // Parallel compare; duplicate pages map identically so OR-ing is safe
    always_comb begin
        hit     = 1'b0;
        hit_ppn = '0;
        hit_unc = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (valid[i] && (vpn_tab[i] == lk_vpn)) begin
                hit     = 1'b1;
                hit_ppn = hit_ppn | ppn_tab[i];
                hit_unc = hit_unc | unc_tab[i];
            end
        end
        // Fill in this cycle is visible to a lookup sampled at the same edge
        if (fill_we && !flush && (fill_vpn == lk_vpn)) begin
            hit     = 1'b1;
            hit_ppn = fill_ppn;
            hit_unc = fill_uncache;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            miss <= 1'b0;
        end else begin
            miss <= req & ~hit;
        end
    end

    always_ff @(posedge clk) begin
        paddr   <= {hit_ppn, vaddr[PAGE_OFS_W-1:0]};
        uncache <= hit_unc;
    end

    // Flush wins over a fill
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we && !flush) begin
            vpn_tab[fill_way] <= fill_vpn;
            ppn_tab[fill_way] <= fill_ppn;
            unc_tab[fill_way] <= fill_uncache;
        end
    end

endmodule

`default_nettype wire

//--- dtlb/miss_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module miss_arbiter
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic [LOAD_PORTS-1:0]                    lmiss,
    input  logic [LOAD_PORTS-1:0][VADDR_W-1:0]       lvaddr,
    input  logic [LOAD_PORTS-1:0][LOAD_BANK_W-1:0]   lidx,
    input  logic [STORE_PORTS-1:0]                   smiss,
    input  logic [STORE_PORTS-1:0][VADDR_W-1:0]      svaddr,
    input  logic [STORE_PORTS-1:0][STORE_BANK_W-1:0] sidx,
    output logic [LOAD_PORTS-1:0]                    lcancel,
    output logic [STORE_PORTS-1:0]                   scancel,
    output logic                                     req,
    output logic [SRC_W-1:0]                         req_src,
    output l2_tag_u                                  req_tag,
    output logic [VADDR_W-1:0]                       req_vaddr
);

    // Delayed copies, aligned with the registered miss from the arrays
    logic [LOAD_PORTS-1:0][VADDR_W-1:0]       lvaddr_q;
    logic [LOAD_PORTS-1:0][LOAD_BANK_W-1:0]   lidx_q;
    logic [STORE_PORTS-1:0][VADDR_W-1:0]      svaddr_q;
    logic [STORE_PORTS-1:0][STORE_BANK_W-1:0] sidx_q;

    logic                     any_l, any_s;
    logic [LOAD_PORTS-1:0]    lwin;
    logic [STORE_PORTS-1:0]   swin;
    logic [VADDR_W-1:0]       l_vaddr, s_vaddr;
    l2_tag_u                  l_tag, s_tag;
    logic [LOAD_PORTS-1:0]    lcancel_q;
    logic [STORE_PORTS-1:0]   scancel_q;

    always_ff @(posedge clk) begin
        lvaddr_q <= lvaddr;
        lidx_q   <= lidx;
        svaddr_q <= svaddr;
        sidx_q   <= sidx;
    end

    // Lowest missing port wins within each group
    always_comb begin
        any_l   = 1'b0;
        any_s   = 1'b0;
        lwin    = '0;
        swin    = '0;
        l_vaddr = '0;
        s_vaddr = '0;
        l_tag   = '0;
        s_tag   = '0;
        for (int i = 0; i < LOAD_PORTS; i++) begin
            if (lmiss[i] && !any_l) begin
                any_l         = 1'b1;
                lwin[i]       = 1'b1;
                l_vaddr       = lvaddr_q[i];
                l_tag.ld.port = 1'(i);
                l_tag.ld.idx  = lidx_q[i];
            end
        end
        for (int i = 0; i < STORE_PORTS; i++) begin
            if (smiss[i] && !any_s) begin
                any_s         = 1'b1;
                swin[i]       = 1'b1;
                s_vaddr       = svaddr_q[i];
                s_tag.st.port = 1'(i);
                s_tag.st.idx  = sidx_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            req       <= 1'b0;
            lcancel_q <= '0;
            scancel_q <= '0;
        end else begin
            req       <= any_l | any_s;
            // Store beats every load
            lcancel_q <= lmiss & ~(any_s ? '0 : lwin);
            scancel_q <= smiss & ~swin;
        end
    end

    always_ff @(posedge clk) begin
        req_src   <= any_s ? SRC_STORE : SRC_LOAD;
        req_tag   <= any_s ? s_tag : l_tag;
        req_vaddr <= any_s ? s_vaddr : l_vaddr;
    end

    assign lcancel = lcancel_q & {LOAD_PORTS{~flush}};
    assign scancel = scancel_q & {STORE_PORTS{~flush}};

endmodule

`default_nettype wire

//--- dtlb/tlb_repeater.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_repeater
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               in_req,
    input  logic [SRC_W-1:0]   in_src,
    input  l2_tag_u            in_tag,
    input  logic [VADDR_W-1:0] in_vaddr,
    input  logic               resp_valid,
    input  logic [SRC_W-1:0]   resp_src,
    input  l2_tag_u            resp_tag,
    input  logic [VPN_W-1:0]   resp_vpn,
    input  logic [PPN_W-1:0]   resp_ppn,
    input  logic               resp_uncache,
    input  logic               resp_error,
    output logic               out_req,
    output logic [SRC_W-1:0]   out_src,
    output l2_tag_u            out_tag,
    output logic [VADDR_W-1:0] out_vaddr,
    output logic               dly_valid,
    output logic [SRC_W-1:0]   dly_src,
    output l2_tag_u            dly_tag,
    output logic [VPN_W-1:0]   dly_vpn,
    output logic [PPN_W-1:0]   dly_ppn,
    output logic               dly_uncache,
    output logic               dly_error
);

    // Strobes in both directions die on flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_req   <= 1'b0;
            dly_valid <= 1'b0;
        end else begin
            out_req   <= in_req;
            dly_valid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_src     <= in_src;
        out_tag     <= in_tag;
        out_vaddr   <= in_vaddr;
        dly_src     <= resp_src;
        dly_tag     <= resp_tag;
        dly_vpn     <= resp_vpn;
        dly_ppn     <= resp_ppn;
        dly_uncache <= resp_uncache;
        dly_error   <= resp_error;
    end

endmodule

`default_nettype wire

//--- dtlb/refill_unit.sv
`timescale 1ns/1ps
`default_nettype none

module refill_unit
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
#(
    parameter int ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       resp_valid,
    input  logic [SRC_W-1:0]           resp_src,
    input  l2_tag_u                    resp_tag,
    input  logic [VPN_W-1:0]           resp_vpn,
    input  logic [PPN_W-1:0]           resp_ppn,
    input  logic                       resp_uncache,
    input  logic                       resp_error,
    output logic                       fill_we,
    output logic [$clog2(ENTRIES)-1:0] fill_way,
    output logic [VPN_W-1:0]           fill_vpn,
    output logic [PPN_W-1:0]           fill_ppn,
    output logic                       fill_uncache,
    output logic [LOAD_PORTS-1:0]      lwb,
    output logic [LOAD_PORTS-1:0]      lwb_error,
    output logic [STORE_PORTS-1:0]     swb,
    output logic [STORE_PORTS-1:0]     swb_error
);

    logic                   flush_q;
    logic                   good;
    logic [15:0]            lfsr;
    logic [LOAD_PORTS-1:0]  lwb_d;
    logic [STORE_PORTS-1:0] swb_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush;
        end
    end

    // Taps 16,14,13,11, runs every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    assign good = resp_valid & (resp_src != SRC_NONE) & ~flush & ~flush_q;

    // Same way to every copy keeps them identical
    assign fill_we      = good & ~resp_error;
    assign fill_way     = lfsr[$clog2(ENTRIES)-1:0];
    assign fill_vpn     = resp_vpn;
    assign fill_ppn     = resp_ppn;
    assign fill_uncache = resp_uncache;

    always_comb begin
        lwb_d = '0;
        swb_d = '0;
        if (good && (resp_src == SRC_LOAD)) begin
            lwb_d[resp_tag.ld.port] = 1'b1;
        end
        if (good && (resp_src == SRC_STORE)) begin
            swb_d[resp_tag.st.port] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lwb       <= '0;
            lwb_error <= '0;
            swb       <= '0;
            swb_error <= '0;
        end else begin
            lwb       <= lwb_d;
            lwb_error <= lwb_d & {LOAD_PORTS{resp_error}};
            swb       <= swb_d;
            swb_error <= swb_d & {STORE_PORTS{resp_error}};
        end
    end

endmodule

`default_nettype wire

//--- rtl/dtlb.sv
`timescale 1ns/1ps
`default_nettype none

module dtlb
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
#(
    parameter int ENTRIES = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic [LOAD_PORTS-1:0]                    lreq,
    input  logic [LOAD_PORTS-1:0][VADDR_W-1:0]       laddr,
    input  logic [LOAD_PORTS-1:0][LOAD_BANK_W-1:0]   lidx,
    input  logic [STORE_PORTS-1:0]                   sreq,
    input  logic [STORE_PORTS-1:0][VADDR_W-1:0]      saddr,
    input  logic [STORE_PORTS-1:0][STORE_BANK_W-1:0] sidx,
    input  logic                                     l2_resp_valid,
    input  logic [SRC_W-1:0]                         l2_resp_src,
    input  l2_tag_u                                  l2_resp_tag,
    input  logic [VPN_W-1:0]                         l2_resp_vpn,
    input  logic [PPN_W-1:0]                         l2_resp_ppn,
    input  logic                                     l2_resp_uncache,
    input  logic                                     l2_resp_error,
    output logic [LOAD_PORTS-1:0]                    lmiss,
    output logic [LOAD_PORTS-1:0][PADDR_W-1:0]       lpaddr,
    output logic [LOAD_PORTS-1:0]                    luncache,
    output logic [LOAD_PORTS-1:0]                    lcancel,
    output logic [LOAD_PORTS-1:0]                    lwb,
    output logic [LOAD_PORTS-1:0]                    lwb_error,
    output logic [STORE_PORTS-1:0]                   smiss,
    output logic [STORE_PORTS-1:0][PADDR_W-1:0]      spaddr,
    output logic [STORE_PORTS-1:0]                   suncache,
    output logic [STORE_PORTS-1:0]                   scancel,
    output logic [STORE_PORTS-1:0]                   swb,
    output logic [STORE_PORTS-1:0]                   swb_error,
    output logic                                     l2_req,
    output logic [SRC_W-1:0]                         l2_req_src,
    output l2_tag_u                                  l2_req_tag,
    output logic [VADDR_W-1:0]                       l2_req_vaddr
);

    logic                       fill_we;
    logic [$clog2(ENTRIES)-1:0] fill_way;
    logic [VPN_W-1:0]           fill_vpn;
    logic [PPN_W-1:0]           fill_ppn;
    logic                       fill_uncache;

    logic               arb_req;
    logic [SRC_W-1:0]   arb_src;
    l2_tag_u            arb_tag;
    logic [VADDR_W-1:0] arb_vaddr;

    logic               dly_valid;
    logic [SRC_W-1:0]   dly_src;
    l2_tag_u            dly_tag;
    logic [VPN_W-1:0]   dly_vpn;
    logic [PPN_W-1:0]   dly_ppn;
    logic               dly_uncache;
    logic               dly_error;

    // One translation copy per port
    for (genvar i = 0; i < LOAD_PORTS; i++) begin : g_load
        tlb_array #(.ENTRIES(ENTRIES)) u_ltlb (
            .clk, .rst, .flush,
            .req(lreq[i]), .vaddr(laddr[i]),
            .fill_we, .fill_way, .fill_vpn, .fill_ppn, .fill_uncache,
            .miss(lmiss[i]), .paddr(lpaddr[i]), .uncache(luncache[i])
        );
    end

    for (genvar i = 0; i < STORE_PORTS; i++) begin : g_store
        tlb_array #(.ENTRIES(ENTRIES)) u_stlb (
            .clk, .rst, .flush,
            .req(sreq[i]), .vaddr(saddr[i]),
            .fill_we, .fill_way, .fill_vpn, .fill_ppn, .fill_uncache,
            .miss(smiss[i]), .paddr(spaddr[i]), .uncache(suncache[i])
        );
    end

    miss_arbiter u_arb (
        .clk, .rst, .flush,
        .lmiss, .lvaddr(laddr), .lidx,
        .smiss, .svaddr(saddr), .sidx,
        .lcancel, .scancel,
        .req(arb_req), .req_src(arb_src), .req_tag(arb_tag), .req_vaddr(arb_vaddr)
    );

    tlb_repeater u_rep (
        .clk, .rst, .flush,
        .in_req(arb_req), .in_src(arb_src), .in_tag(arb_tag), .in_vaddr(arb_vaddr),
        .resp_valid(l2_resp_valid), .resp_src(l2_resp_src), .resp_tag(l2_resp_tag),
        .resp_vpn(l2_resp_vpn), .resp_ppn(l2_resp_ppn),
        .resp_uncache(l2_resp_uncache), .resp_error(l2_resp_error),
        .out_req(l2_req), .out_src(l2_req_src), .out_tag(l2_req_tag),
        .out_vaddr(l2_req_vaddr),
        .dly_valid, .dly_src, .dly_tag, .dly_vpn, .dly_ppn, .dly_uncache, .dly_error
    );

    refill_unit #(.ENTRIES(ENTRIES)) u_refill (
        .clk, .rst, .flush,
        .resp_valid(dly_valid), .resp_src(dly_src), .resp_tag(dly_tag),
        .resp_vpn(dly_vpn), .resp_ppn(dly_ppn),
        .resp_uncache(dly_uncache), .resp_error(dly_error),
        .fill_we, .fill_way, .fill_vpn, .fill_ppn, .fill_uncache,
        .lwb, .lwb_error, .swb, .swb_error
    );

endmodule

`default_nettype wire

//--- verif/l2_tlb_model.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tlb_model
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
#(
    parameter logic [31:0] SEED  = 32'h94fc7301,
    parameter int          SLOTS = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  logic [SRC_W-1:0]   req_src,
    input  logic [TAG_W-1:0]   req_tag,
    input  logic [VADDR_W-1:0] req_vaddr,
    output logic               resp_valid,
    output logic [SRC_W-1:0]   resp_src,
    output logic [TAG_W-1:0]   resp_tag,
    output logic [VPN_W-1:0]   resp_vpn,
    output logic [PPN_W-1:0]   resp_ppn,
    output logic               resp_uncache,
    output logic               resp_error,
    output logic               overflow
);

    integer           seed = SEED;
    int               now;
    bit               busy  [SLOTS];
    int               due   [SLOTS];
    logic [SRC_W-1:0] p_src [SLOTS];
    logic [TAG_W-1:0] p_tag [SLOTS];
    logic [VPN_W-1:0] p_vpn [SLOTS];

    initial begin
        resp_valid   = 1'b0;
        resp_src     = '0;
        resp_tag     = '0;
        resp_vpn     = '0;
        resp_ppn     = '0;
        resp_uncache = 1'b0;
        resp_error   = 1'b0;
        overflow     = 1'b0;
    end

    // At most one answer per cycle, any pending slot that is due
    always @(posedge clk) begin
        int pick;
        int slot;
        if (rst) begin
            now = 0;
            resp_valid <= 1'b0;
            overflow   <= 1'b0;
            for (int i = 0; i < SLOTS; i++) begin
                busy[i] = 1'b0;
            end
        end else begin
            now++;
            pick = -1;
            for (int i = 0; i < SLOTS; i++) begin
                if (busy[i] && due[i] <= now && pick < 0) begin
                    pick = i;
                end
            end
            resp_valid <= (pick >= 0);
            if (pick >= 0) begin
                busy[pick] = 1'b0;
                resp_src     <= p_src[pick];
                resp_tag     <= p_tag[pick];
                resp_vpn     <= p_vpn[pick];
                resp_ppn     <= p_vpn[pick] ^ 20'h5A5A5;  // Fixed mapping
                resp_uncache <= p_vpn[pick][0];
                resp_error   <= p_vpn[pick][19];
            end
            if (req) begin
                slot = -1;
                for (int i = 0; i < SLOTS; i++) begin
                    if (!busy[i] && slot < 0) begin
                        slot = i;
                    end
                end
                if (slot < 0) begin
                    overflow <= 1'b1;
                end else begin
                    busy[slot]  = 1'b1;
                    due[slot]   = now + 2 + int'({$random(seed)} % 5);
                    p_src[slot] = req_src;
                    p_tag[slot] = req_tag;
                    p_vpn[slot] = req_vaddr[VADDR_W-1:PAGE_OFS_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/dtlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dtlb_tb
    import dtlb_cfg_pkg::*;
    import dtlb_msg_pkg::*;
();

    localparam int ENTRIES     = 8;
    localparam int TEST_CYCLES = 800;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic [LOAD_PORTS-1:0]                    lreq;
    logic [LOAD_PORTS-1:0][VADDR_W-1:0]       laddr;
    logic [LOAD_PORTS-1:0][LOAD_BANK_W-1:0]   lidx;
    logic [STORE_PORTS-1:0]                   sreq;
    logic [STORE_PORTS-1:0][VADDR_W-1:0]      saddr;
    logic [STORE_PORTS-1:0][STORE_BANK_W-1:0] sidx;
    logic                                     l2_resp_valid;
    logic [SRC_W-1:0]                         l2_resp_src;
    logic [TAG_W-1:0]                         l2_resp_tag;
    logic [VPN_W-1:0]                         l2_resp_vpn;
    logic [PPN_W-1:0]                         l2_resp_ppn;
    logic                                     l2_resp_uncache;
    logic                                     l2_resp_error;
    logic                                     model_overflow;
    logic [LOAD_PORTS-1:0]                    lmiss, luncache, lcancel, lwb, lwb_error;
    logic [LOAD_PORTS-1:0][PADDR_W-1:0]       lpaddr;
    logic [STORE_PORTS-1:0]                   smiss, suncache, scancel, swb, swb_error;
    logic [STORE_PORTS-1:0][PADDR_W-1:0]      spaddr;
    logic                                     l2_req;
    logic [SRC_W-1:0]                         l2_req_src;
    l2_tag_u                                  l2_req_tag;
    logic [VADDR_W-1:0]                       l2_req_vaddr;

    integer seed = 32'h94fc7301;
    bit     sb [logic [VPN_W-1:0]];  // Pages filled since the last flush

    // Inputs and outputs as the DUT saw them one to three cycles back
    logic [LOAD_PORTS-1:0][VADDR_W-1:0]       laddr1 = '0, laddr2 = '0, laddr3 = '0;
    logic [LOAD_PORTS-1:0][LOAD_BANK_W-1:0]   lidx1 = '0, lidx2 = '0, lidx3 = '0;
    logic [STORE_PORTS-1:0][VADDR_W-1:0]      saddr1 = '0, saddr2 = '0, saddr3 = '0;
    logic [STORE_PORTS-1:0][STORE_BANK_W-1:0] sidx1 = '0, sidx2 = '0, sidx3 = '0;
    logic [LOAD_PORTS-1:0]  lreq1 = '0, lmiss1 = '0, lmiss2 = '0;
    logic [STORE_PORTS-1:0] sreq1 = '0, smiss1 = '0, smiss2 = '0;
    logic f1 = 1'b0, f2 = 1'b0;
    logic rv1 = 1'b0, rerr1 = 1'b0;
    logic [SRC_W-1:0] rsrc1 = '0;
    logic [TAG_W-1:0] rtag1 = '0;
    logic [VPN_W-1:0] rvpn1 = '0;
    logic [LOAD_PORTS-1:0]  exp_lwb = '0, exp_lwb_err = '0;
    logic [STORE_PORTS-1:0] exp_swb = '0, exp_swb_err = '0;

    always #10 clk = ~clk;

    dtlb #(.ENTRIES(ENTRIES)) dtlb_inst (
        .clk, .rst, .flush, .lreq, .laddr, .lidx, .sreq, .saddr, .sidx,
        .l2_resp_valid, .l2_resp_src, .l2_resp_tag, .l2_resp_vpn, .l2_resp_ppn,
        .l2_resp_uncache, .l2_resp_error,
        .lmiss, .lpaddr, .luncache, .lcancel, .lwb, .lwb_error,
        .smiss, .spaddr, .suncache, .scancel, .swb, .swb_error,
        .l2_req, .l2_req_src, .l2_req_tag, .l2_req_vaddr
    );

    l2_tlb_model #(.SEED(32'h94fc7301)) l2_model (
        .clk, .rst, .req(l2_req), .req_src(l2_req_src), .req_tag(l2_req_tag),
        .req_vaddr(l2_req_vaddr), .resp_valid(l2_resp_valid), .resp_src(l2_resp_src),
        .resp_tag(l2_resp_tag), .resp_vpn(l2_resp_vpn), .resp_ppn(l2_resp_ppn),
        .resp_uncache(l2_resp_uncache), .resp_error(l2_resp_error),
        .overflow(model_overflow)
    );

    function automatic logic [VPN_W-1:0] page_vpn(input int i);
        return (i == 11) ? 20'h80011 : 20'h00120 + 20'(i * 7);  // Page 11 has bit 19 set
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_lookup(input string name, input logic req, input logic [31:0] va,
                                input logic miss, input logic [31:0] pa, input logic unc);
        logic [VPN_W-1:0] vpn;
        logic [31:0]      exp_pa;
        vpn    = va[31:12];
        exp_pa = {vpn ^ 20'h5A5A5, va[11:0]};
        assert (!miss || req) else report_fail($sformatf("FAIL %s got %h expected %h",
                                                         name, miss, 1'b0));
        if (req && !sb.exists(vpn)) begin
            assert (miss) else report_fail($sformatf("FAIL %s got %h expected %h",
                                                     name, miss, 1'b1));
        end
        if (req && !miss) begin
            assert (sb.exists(vpn)) else report_fail($sformatf(
                "%s hit on page %h that was never filled", name, vpn));
            assert (pa == exp_pa) else report_fail($sformatf(
                "FAIL %s paddr got %h expected %h", name, pa, exp_pa));
            assert (unc == vpn[0]) else report_fail($sformatf(
                "FAIL %s uncache got %h expected %h", name, unc, vpn[0]));
        end
    endtask

    // Outputs checked at the falling edge
    always @(negedge clk) begin
        logic             exp_req;
        logic [SRC_W-1:0] exp_src;
        logic [TAG_W-1:0] exp_tag;
        logic [31:0]      exp_va;
        logic [LOAD_PORTS-1:0] exp_lc;
        logic             lower;
        logic             good;
        int               w;
        if (!rst) begin
            for (int p = 0; p < LOAD_PORTS; p++) begin
                check_lookup($sformatf("lmiss[%0d]", p), lreq1[p], laddr1[p], lmiss[p],
                             lpaddr[p], luncache[p]);
            end
            check_lookup("smiss[0]", sreq1[0], saddr1[0], smiss[0], spaddr[0], suncache[0]);

            exp_req = ((|lmiss2) | (|smiss2)) & ~f2 & ~f1;
            assert (l2_req == exp_req) else report_fail($sformatf(
                "FAIL l2_req got %h expected %h", l2_req, exp_req));
            if (exp_req) begin
                if (smiss2[0]) begin
                    exp_src = SRC_STORE;
                    exp_va  = saddr3[0];
                    exp_tag = {1'b0, sidx3[0], 2'b00};
                end else begin
                    w       = lmiss2[0] ? 0 : 1;
                    exp_src = SRC_LOAD;
                    exp_va  = laddr3[w];
                    exp_tag = {w[0], lidx3[w], 1'b0};
                end
                assert (l2_req_src == exp_src) else report_fail($sformatf(
                    "FAIL l2_req_src got %h expected %h", l2_req_src, exp_src));
                assert (l2_req_tag == exp_tag) else report_fail($sformatf(
                    "FAIL l2_req_tag got %h expected %h", l2_req_tag, exp_tag));
                assert (l2_req_vaddr == exp_va) else report_fail($sformatf(
                    "FAIL l2_req_vaddr got %h expected %h", l2_req_vaddr, exp_va));
            end

            // A load loses to the store and to any lower missing load
            lower = smiss1[0];
            for (int p = 0; p < LOAD_PORTS; p++) begin
                exp_lc[p] = lmiss1[p] & lower & ~f1 & ~flush;
                lower     = lower | lmiss1[p];
            end
            assert (lcancel == exp_lc) else report_fail($sformatf(
                "FAIL lcancel got %h expected %h", lcancel, exp_lc));
            assert (scancel == '0) else report_fail($sformatf(
                "FAIL scancel got %h expected %h", scancel, 1'b0));
            assert (lwb == exp_lwb && lwb_error == exp_lwb_err) else report_fail($sformatf(
                "FAIL lwb/lwb_error got %h/%h expected %h/%h",
                lwb, lwb_error, exp_lwb, exp_lwb_err));
            assert (swb == exp_swb && swb_error == exp_swb_err) else report_fail($sformatf(
                "FAIL swb/swb_error got %h/%h expected %h/%h",
                swb, swb_error, exp_swb, exp_swb_err));
            assert (!model_overflow) else report_fail("L2 model ran out of request slots");
        end

        if (f1) begin
            sb.delete();
        end
        // Response seen last cycle survives unless a flush touches it
        good        = rv1 & (rsrc1 != SRC_NONE) & ~f1 & ~flush;
        exp_lwb     = '0;
        exp_lwb_err = '0;
        exp_swb     = '0;
        exp_swb_err = '0;
        if (good && rsrc1 == SRC_LOAD) begin
            exp_lwb[rtag1[5]]     = 1'b1;
            exp_lwb_err[rtag1[5]] = rerr1;
        end
        if (good && rsrc1 == SRC_STORE) begin
            exp_swb[0]     = 1'b1;
            exp_swb_err[0] = rerr1;
        end
        if (good && !rerr1) begin
            sb[rvpn1] = 1'b1;
        end

        laddr3 = laddr2;
        laddr2 = laddr1;
        laddr1 = laddr;
        lidx3  = lidx2;
        lidx2  = lidx1;
        lidx1  = lidx;
        saddr3 = saddr2;
        saddr2 = saddr1;
        saddr1 = saddr;
        sidx3  = sidx2;
        sidx2  = sidx1;
        sidx1  = sidx;
        lreq1  = lreq;
        sreq1  = sreq;
        lmiss2 = lmiss1;
        lmiss1 = lmiss;
        smiss2 = smiss1;
        smiss1 = smiss;
        f2     = f1;
        f1     = flush;
        rv1    = l2_resp_valid;
        rsrc1  = l2_resp_src;
        rtag1  = l2_resp_tag;
        rvpn1  = l2_resp_vpn;
        rerr1  = l2_resp_error;
    end

    task automatic lookup(input logic [1:0] lv, input logic sv, input logic [31:0] va0,
                          input logic [31:0] va1, input logic [31:0] vs);
        @(posedge clk);
        lreq     <= lv;
        laddr[0] <= va0;
        laddr[1] <= va1;
        lidx[0]  <= 4'h3;
        lidx[1]  <= 4'hA;
        sreq[0]  <= sv;
        saddr[0] <= vs;
        sidx[0]  <= 3'h5;
        @(posedge clk);
        lreq <= '0;
        sreq <= '0;
    endtask

    task automatic wait_wb(input bit store, input int p);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < 40 && !seen; n++) begin
            @(negedge clk);
            seen = store ? swb[0] : lwb[p];
        end
        if (!seen) begin
            report_fail($sformatf("no writeback on %s port %0d within 40 cycles",
                                  store ? "store" : "load", p));
        end
    endtask

    task automatic wait_resp();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < 40 && !seen; n++) begin
            @(negedge clk);
            seen = l2_resp_valid;
        end
        if (!seen) begin
            report_fail("no L2 response within 40 cycles");
        end
    endtask

    initial begin
        rst   = 1'b1;
        flush = 1'b0;
        lreq  = '0;
        laddr = '0;
        lidx  = '0;
        sreq  = '0;
        saddr = '0;
        sidx  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);

        // Cold miss, refill, then hits on both load ports
        lookup(2'b01, 1'b0, {page_vpn(0), 12'h234}, '0, '0);
        wait_wb(1'b0, 0);
        lookup(2'b11, 1'b0, {page_vpn(0), 12'h010}, {page_vpn(0), 12'hffc}, '0);
        @(negedge clk);
        assert (lmiss == 2'b00) else report_fail($sformatf(
            "FAIL lmiss got %h expected %h", lmiss, 2'b00));

        // Three misses at once, store wins
        lookup(2'b11, 1'b1, {page_vpn(1), 12'h100}, {page_vpn(2), 12'h200},
               {page_vpn(3), 12'h300});
        wait_wb(1'b1, 0);
        lookup(2'b11, 1'b0, {page_vpn(1), 12'h104}, {page_vpn(2), 12'h204}, '0);
        wait_wb(1'b0, 0);
        lookup(2'b10, 1'b0, '0, {page_vpn(2), 12'h208}, '0);
        wait_wb(1'b0, 1);
        lookup(2'b00, 1'b1, '0, '0, {page_vpn(3), 12'h30c});

        // L2 error page never gets filled
        lookup(2'b10, 1'b0, '0, {page_vpn(11), 12'h040}, '0);
        wait_wb(1'b0, 1);
        lookup(2'b10, 1'b0, '0, {page_vpn(11), 12'h044}, '0);
        wait_wb(1'b0, 1);

        // Flush empties every copy
        repeat (12) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        lookup(2'b11, 1'b1, {page_vpn(0), 12'h0}, {page_vpn(1), 12'h0}, {page_vpn(3), 12'h0});
        lookup(2'b01, 1'b0, {page_vpn(5), 12'h500}, '0, '0);
        wait_resp();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (12) @(posedge clk);

        // Random traffic over 12 pages
        repeat (300) begin
            @(posedge clk);
            for (int p = 0; p < LOAD_PORTS; p++) begin
                lreq[p]  <= 1'($random(seed));
                laddr[p] <= {page_vpn({$random(seed)} % 12), 12'($random(seed))};
                lidx[p]  <= 4'($random(seed));
            end
            sreq[0]  <= 1'($random(seed));
            saddr[0] <= {page_vpn({$random(seed)} % 12), 12'($random(seed))};
            sidx[0]  <= 3'($random(seed));
        end
        @(posedge clk);
        lreq <= '0;
        sreq <= '0;
        repeat (20) @(posedge clk);

        $display("test passed");
        $finish;
    end

    // Twice the clock period per test cycle plus a margin
    initial begin
        #(TEST_CYCLES * 40 + 2000);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- dtlb.f
common/dtlb_cfg_pkg.sv
common/dtlb_msg_pkg.sv
dtlb/tlb_array.sv
dtlb/miss_arbiter.sv
dtlb/tlb_repeater.sv
dtlb/refill_unit.sv
rtl/dtlb.sv
verif/l2_tlb_model.sv
verif/dtlb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DTLB testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module dtlb_tb -Mdir obj_dir -f dtlb.f &&
out="$(./obj_dir/Vdtlb_tb)" ; echo "$out" ;
echo "$out" | grep -qx "test passed" && echo "simulation ok" || { echo "simulation failed"; exit 1; }
